/* common/dds_pkg.sv */
// shared constants, register map and register word layout of the DDS bank, imported by RTL and testbench
package dds_pkg;

  // bank size and datapath widths
  localparam int CHANNELS = 8;
  localparam int PHASE_BITS = 24;
  // top phase bits that address one full cosine period
  localparam int QUANT_BITS = 8;
  localparam int DATA_WIDTH = 16;
  // peak value of a sample, kept one below full scale so negation never overflows
  localparam int AMPLITUDE = 32767;

  // AXI4-Lite bus geometry
  localparam int AXI_ADDR_WIDTH = 6;
  localparam int AXI_DATA_WIDTH = 32;

  // increment of channel n sits at base + 4n, the control word follows the last one
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_PHASE_BASE = 6'h00;
  localparam logic [AXI_ADDR_WIDTH-1:0] ADDR_CONTROL = 6'h20;

  // AXI response codes that the slave produces
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // cycles from an accumulator update to the registered table output
  localparam int CHANNEL_LATENCY = 2;

  // one bus word, read as an increment or as the control word depending on the address
  typedef union packed {
    struct packed {
      logic [AXI_DATA_WIDTH-PHASE_BITS-1:0] unused;
      logic [PHASE_BITS-1:0] inc;
    } phase;
    struct packed {
      logic [AXI_DATA_WIDTH-CHANNELS-2:0] unused;
      logic clear;
      logic [CHANNELS-1:0] enable;
    } control;
  } dds_reg_word_t;

endpackage

/* source/dds_regs.sv */
// AXI4-Lite register file that holds the channel phase increments and the enable and clear control
`timescale 1ns/10ps

module dds_regs
  import dds_pkg::*;
(
  input  logic                        ps_clk,
  input  logic                        rst,
  input  logic [AXI_ADDR_WIDTH-1:0]   awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [AXI_DATA_WIDTH-1:0]   wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [AXI_ADDR_WIDTH-1:0]   araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [AXI_DATA_WIDTH-1:0]   rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  output logic [PHASE_BITS-1:0]       phase_inc [CHANNELS],
  output logic [CHANNELS-1:0]         enable,
  output logic                        clear
);

  dds_reg_word_t wr_word;
  dds_reg_word_t rd_word;
  logic wr_ready;
  logic wr_accept;
  logic rd_accept;
  logic wr_in_range;
  logic rd_in_range;
  logic [AXI_ADDR_WIDTH-1:0] wr_offset;
  logic [AXI_ADDR_WIDTH-1:0] rd_offset;
  logic [$clog2(CHANNELS)-1:0] wr_index;
  logic [$clog2(CHANNELS)-1:0] rd_index;

  // address and data ready share one flag, so both channels complete on the same edge
  assign awready = wr_ready;
  assign wready = wr_ready;
  assign wr_accept = wr_ready && awvalid && wvalid;
  assign rd_accept = arready && arvalid;

  // everything up to and including the control word is mapped
  assign wr_in_range = awaddr <= ADDR_CONTROL;
  assign rd_in_range = araddr <= ADDR_CONTROL;
  assign wr_offset = awaddr - ADDR_PHASE_BASE;
  assign rd_offset = araddr - ADDR_PHASE_BASE;
  assign wr_index = wr_offset[2 +: $clog2(CHANNELS)];
  assign rd_index = rd_offset[2 +: $clog2(CHANNELS)];
  assign wr_word = wdata;

  // the read word is built through the same union, clear always reads back as zero
  always_comb begin
    rd_word = '0;
    if (araddr == ADDR_CONTROL) begin
      rd_word.control.enable = enable;
    end else begin
      rd_word.phase.inc = phase_inc[rd_index];
    end
  end

  // write path, a new request is only taken once the previous response has gone
  always_ff @(posedge ps_clk) begin
    if (rst) begin
      wr_ready <= 1'b0;
      bvalid <= 1'b0;
      bresp <= RESP_OKAY;
      enable <= '0;
      clear <= 1'b0;
      for (int i = 0; i < CHANNELS; i++) begin
        phase_inc[i] <= '0;
      end
    end else begin
      // clear only lives for the cycle after the accepting edge
      clear <= 1'b0;
      wr_ready <= awvalid && wvalid && !wr_ready && !bvalid;
      if (wr_accept) begin
        bvalid <= 1'b1;
        bresp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        // any strobe writes the whole word, an all-zero strobe writes nothing
        if (wr_in_range && (|wstrb)) begin
          if (awaddr == ADDR_CONTROL) begin
            enable <= wr_word.control.enable;
            clear <= wr_word.control.clear;
          end else begin
            phase_inc[wr_index] <= wr_word.phase.inc;
          end
        end
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // read path with the same one-request-at-a-time rule
  always_ff @(posedge ps_clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid <= 1'b0;
      rresp <= RESP_OKAY;
      rdata <= '0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_accept) begin
        rvalid <= 1'b1;
        rresp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        rdata <= rd_in_range ? rd_word : '0;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

/* dds_channel/quarter_wave_cos.sv */
// cosine lookup over the full circle built from a first-quadrant table, two register stages deep
`timescale 1ns/10ps

module quarter_wave_cos
  import dds_pkg::*;
(
  input  logic                         ps_clk,
  input  logic                         rst,
  input  logic [QUANT_BITS-1:0]        phase,
  output logic signed [DATA_WIDTH-1:0] value
);

  localparam int QUARTER_BITS = QUANT_BITS - 2;
  localparam int QUARTER_POINTS = 2 ** QUARTER_BITS;
  localparam real PI = 3.14159265358979;

  logic signed [DATA_WIDTH-1:0] rom [QUARTER_POINTS];
  logic [QUARTER_BITS-1:0] addr_q;
  logic negate_q;

  // table points sit half a step off the axes, so every quadrant is an exact mirror
  function automatic logic signed [DATA_WIDTH-1:0] point_value(input int k);
    real angle;
    angle = 2.0 * PI * (real'(k) + 0.5) / real'(2 ** QUANT_BITS);
    // the int cast rounds to nearest
    return DATA_WIDTH'(int'(real'(AMPLITUDE) * $cos(angle)));
  endfunction

  // the quadrant contents are fixed at elaboration
  for (genvar k = 0; k < QUARTER_POINTS; k++) begin : g_rom
    assign rom[k] = point_value(k);
  end

  // stage one folds the phase onto the first quadrant
  always_ff @(posedge ps_clk) begin
    if (rst) begin
      addr_q <= '0;
      negate_q <= 1'b0;
    end else begin
      // odd quadrants run the table backwards
      if (phase[QUANT_BITS-2]) begin
        addr_q <= ~phase[QUARTER_BITS-1:0];
      end else begin
        addr_q <= phase[QUARTER_BITS-1:0];
      end
      // quadrants 1 and 2 sit in the negative half of the cosine
      negate_q <= phase[QUANT_BITS-1] ^ phase[QUANT_BITS-2];
    end
  end

  // stage two reads the table and restores the sign
  always_ff @(posedge ps_clk) begin
    if (rst) begin
      value <= '0;
    end else if (negate_q) begin
      value <= -rom[addr_q];
    end else begin
      value <= rom[addr_q];
    end
  end

endmodule

/* dds_channel/dds_channel.sv */
// one DDS channel, a phase accumulator feeding the cosine table, with enable masking and clear restart
`timescale 1ns/10ps

module dds_channel
  import dds_pkg::*;
(
  input  logic                         ps_clk,
  input  logic                         rst,
  input  logic [PHASE_BITS-1:0]        phase_inc,
  input  logic                         enable,
  input  logic                         clear,
  output logic signed [DATA_WIDTH-1:0] sample,
  output logic                         running
);

  logic [PHASE_BITS-1:0] phase_acc;
  logic [CHANNEL_LATENCY-1:0] run_pipe;
  // one stage more than the table, the first stage tracks the accumulator itself
  logic [CHANNEL_LATENCY:0] en_pipe;
  logic signed [DATA_WIDTH-1:0] table_value;

  // clear wins over enable so every channel restarts at phase zero together
  always_ff @(posedge ps_clk) begin
    if (rst) begin
      phase_acc <= '0;
    end else if (clear) begin
      phase_acc <= '0;
    end else if (enable) begin
      phase_acc <= phase_acc + phase_inc;
    end else begin
      // a disabled channel parks at zero, ready for its next start
      phase_acc <= '0;
    end
  end

  // running follows the accumulator value of the clear through the table stages
  always_ff @(posedge ps_clk) begin
    if (rst) begin
      run_pipe <= '0;
      en_pipe <= '0;
    end else begin
      if (clear) begin
        run_pipe <= '0;
      end else begin
        run_pipe <= {run_pipe[CHANNEL_LATENCY-2:0], 1'b1};
      end
      en_pipe <= {en_pipe[CHANNEL_LATENCY-1:0], enable};
    end
  end

  // only the top phase bits address the table, the rest just carry fine frequency
  quarter_wave_cos quarter_wave_cos_i (
    .ps_clk,
    .rst,
    .phase (phase_acc[PHASE_BITS-1 -: QUANT_BITS]),
    .value (table_value)
  );

  // the mask is delayed like the data so that a sample and its enable line up
  assign sample = en_pipe[CHANNEL_LATENCY] ? table_value : '0;
  assign running = run_pipe[CHANNEL_LATENCY-1];

endmodule

/* source/sample_packer.sv */
// packs the channel samples into one registered parallel DAC word with its valid flag
`timescale 1ns/10ps

module sample_packer
  import dds_pkg::*;
(
  input  logic                           ps_clk,
  input  logic                           rst,
  input  logic signed [DATA_WIDTH-1:0]   samples [CHANNELS],
  input  logic [CHANNELS-1:0]            running,
  output logic [CHANNELS*DATA_WIDTH-1:0] sample_data,
  output logic                           sample_valid
);

  // channel 0 lands in the low bits of the word
  always_ff @(posedge ps_clk) begin
    for (int i = 0; i < CHANNELS; i++) begin
      sample_data[i*DATA_WIDTH +: DATA_WIDTH] <= samples[i];
    end
  end

  // the word is valid once every channel has flushed its pipeline after a clear
  // disabled channels report running too, so the mask never holds this low
  always_ff @(posedge ps_clk) begin
    if (rst) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= &running;
    end
  end

endmodule

/* source/dds_bank.sv */
// top of the DDS bank, AXI4-Lite register block driving eight channels into the sample packer
`timescale 1ns/10ps

module dds_bank
  import dds_pkg::*;
(
  input  logic                           ps_clk,
  input  logic                           rst,
  input  logic [AXI_ADDR_WIDTH-1:0]      awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [AXI_DATA_WIDTH-1:0]      wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0]    wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  logic [AXI_ADDR_WIDTH-1:0]      araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [AXI_DATA_WIDTH-1:0]      rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready,
  output logic [CHANNELS*DATA_WIDTH-1:0] sample_data,
  output logic                           sample_valid
);

  logic [PHASE_BITS-1:0] phase_inc [CHANNELS];
  logic [CHANNELS-1:0] enable;
  logic clear;
  logic signed [DATA_WIDTH-1:0] samples [CHANNELS];
  logic [CHANNELS-1:0] running;

  dds_regs dds_regs_i (
    .ps_clk, .rst,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .phase_inc, .enable, .clear
  );

  // every channel sees the same clear pulse, which keeps their phases aligned
  for (genvar i = 0; i < CHANNELS; i++) begin : g_channel
    dds_channel dds_channel_i (
      .ps_clk, .rst,
      .phase_inc (phase_inc[i]),
      .enable    (enable[i]),
      .clear,
      .sample    (samples[i]),
      .running   (running[i])
    );
  end

  sample_packer sample_packer_i (
    .ps_clk, .rst,
    .samples, .running,
    .sample_data, .sample_valid
  );

endmodule

/* tb/dds_bank_properties.sv */
// concurrent checks on the AXI4-Lite handshake and the DAC valid flag, bound into the DDS bank top
`timescale 1ns/10ps

module dds_bank_properties
  import dds_pkg::*;
(
  input logic                      ps_clk,
  input logic                      rst,
  input logic [AXI_ADDR_WIDTH-1:0] awaddr,
  input logic                      awvalid,
  input logic                      awready,
  input logic                      wvalid,
  input logic                      wready,
  input logic [1:0]                bresp,
  input logic                      bvalid,
  input logic                      bready,
  input logic                      arvalid,
  input logic                      arready,
  input logic [AXI_DATA_WIDTH-1:0] rdata,
  input logic                      rvalid,
  input logic                      rready,
  input logic                      sample_valid
);

  // number of assertion failures, read by the testbench at the end of the run
  int failures = 0;

  // requests from the master hold until the slave takes them
  assert property (@(posedge ps_clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(awaddr))
  else begin
    $error("awvalid or awaddr changed before the write address was accepted");
    failures++;
  end

  assert property (@(posedge ps_clk) disable iff (rst) wvalid && !wready |=> wvalid)
  else begin
    $error("wvalid dropped before the write data was accepted");
    failures++;
  end

  assert property (@(posedge ps_clk) disable iff (rst) arvalid && !arready |=> arvalid)
  else begin
    $error("arvalid dropped before the read address was accepted");
    failures++;
  end

  // responses from the slave hold their payload under back-pressure
  assert property (@(posedge ps_clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
  else begin
    $error("write response changed while bready was low");
    failures++;
  end

  assert property (@(posedge ps_clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata))
  else begin
    $error("read response changed while rready was low");
    failures++;
  end

  // the DAC word is never flagged valid while the bank is in reset
  assert property (@(posedge ps_clk) rst |=> !sample_valid)
  else begin
    $error("sample_valid high during reset");
    failures++;
  end

  // SLVERR belongs to unmapped addresses only, everything up to the control word is OKAY
  assert property (@(posedge ps_clk) disable iff (rst)
    awvalid && wvalid && awready |=>
      bresp == (($past(awaddr) > ADDR_CONTROL) ? RESP_SLVERR : RESP_OKAY))
  else begin
    $error("write response code does not match the address map");
    failures++;
  end

endmodule

// the top level carries both the register handshake and the packer output
bind dds_bank dds_bank_properties dds_bank_properties_i (
  .ps_clk, .rst,
  .awaddr, .awvalid, .awready,
  .wvalid, .wready,
  .bresp, .bvalid, .bready,
  .arvalid, .arready,
  .rdata, .rvalid, .rready,
  .sample_valid
);

/* tb/dds_bank_tb.sv */
// self-checking testbench for the DDS bank, drives AXI4-Lite traffic and checks the DAC sample stream
`timescale 1ns/10ps

module dds_bank_tb
  import dds_pkg::*;
();

  localparam int STEADY_SAMPLES = 2000;
  localparam int MASK_SAMPLES = 500;
  localparam int RESTART_SAMPLES = 200;
  // running is low for two cycles after a clear, and the packer shifts that gap by one
  localparam int VALID_GAP = 2;
  // register traffic, generously counted, each access at most this many cycles
  localparam int AXI_OPS = 120;
  localparam int AXI_OP_CYCLES = 24;
  localparam int TIMEOUT_CYCLES = 10 + 3 * STEADY_SAMPLES + MASK_SAMPLES + RESTART_SAMPLES
                                  + AXI_OPS * AXI_OP_CYCLES + 2000;

  logic ps_clk;
  logic rst;
  logic [AXI_ADDR_WIDTH-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [AXI_DATA_WIDTH-1:0] wdata;
  logic [AXI_DATA_WIDTH/8-1:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [AXI_ADDR_WIDTH-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [AXI_DATA_WIDTH-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic [CHANNELS*DATA_WIDTH-1:0] sample_data;
  logic sample_valid;

  logic [31:0] lcg_state = 32'he72c;
  int cycles = 0;
  int tests = 0;
  int checks = 0;
  int errors = 0;

  // what the register file should hold after the writes so far
  logic [PHASE_BITS-1:0] model_inc [CHANNELS];
  logic [CHANNELS-1:0] model_mask;
  // mix of very low, middle and near-Nyquist increments, shuffled for each run
  logic [PHASE_BITS-1:0] freq_set [CHANNELS] = '{24'h000001, 24'h000010, 24'h001000,
    24'h0a3d71, 24'h200000, 24'h555555, 24'h7fff00, 24'h7fffff};
  logic [AXI_ADDR_WIDTH-1:0] bad_addrs [4] = '{6'h21, 6'h24, 6'h30, 6'h3c};

  // the main process hands one stream check at a time to the checker
  logic check_req = 1'b0;
  int check_len;
  logic [PHASE_BITS-1:0] check_inc [CHANNELS];
  logic [CHANNELS-1:0] check_mask;

  dds_bank dds_bank_i (.*);

  initial begin
    ps_clk = 1'b0;
    forever #4 ps_clk = ~ps_clk;
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge ps_clk);
      cycles++;
    end
    $display("Run timed out after %0d cycles before all tests finished", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // the upper LCG bits are the well mixed ones
  function automatic int random_below(input int n);
    return int'(lcg_next() >> 16) % n;
  endfunction

  // table point k carries the cosine at the middle of its phase slot
  function automatic logic signed [DATA_WIDTH-1:0] cos_ref(input logic [PHASE_BITS-1:0] phase);
    real point;
    real angle;
    point = real'(phase[PHASE_BITS-1 -: QUANT_BITS]) + 0.5;
    angle = 2.0 * $acos(-1.0) * point / real'(2 ** QUANT_BITS);
    return DATA_WIDTH'(int'(real'(AMPLITUDE) * $cos(angle)));
  endfunction

  task automatic compare_sample(input string name, input logic signed [DATA_WIDTH-1:0] expected,
                                input logic signed [DATA_WIDTH-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic compare_word(input string name, input dds_reg_word_t expected,
                              input dds_reg_word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_resp(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int first_error);
    tests++;
    $display("test %s finished with %0d errors", name, errors - first_error);
  endtask

  task automatic wait_write_response(output logic [1:0] resp);
    bready <= 1'b0;
    repeat (random_below(4)) @(posedge ps_clk);
    bready <= 1'b1;
    do @(posedge ps_clk); while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic write_reg(input logic [AXI_ADDR_WIDTH-1:0] addr,
                           input logic [AXI_DATA_WIDTH-1:0] data, input logic [1:0] expected);
    logic [1:0] resp;
    repeat (random_below(4)) @(posedge ps_clk);
    awaddr <= addr;
    wdata <= data;
    wstrb <= '1;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    do @(posedge ps_clk); while (!awready);
    // address and data are taken on the same edge
    checks++;
    if (wready !== 1'b1) begin
      errors++;
      $display("Error at %0t: wready expected 1, got %b", $time, wready);
    end
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    wait_write_response(resp);
    compare_resp("bresp", expected, resp);
  endtask

  task automatic read_reg(input logic [AXI_ADDR_WIDTH-1:0] addr, input dds_reg_word_t expected,
                          input logic [1:0] expected_resp);
    repeat (random_below(4)) @(posedge ps_clk);
    araddr <= addr;
    arvalid <= 1'b1;
    do @(posedge ps_clk); while (!arready);
    arvalid <= 1'b0;
    // rvalid waits here with rready low for a random stretch
    repeat (random_below(4)) @(posedge ps_clk);
    rready <= 1'b1;
    do @(posedge ps_clk); while (!rvalid);
    rready <= 1'b0;
    compare_resp("rresp", expected_resp, rresp);
    compare_word("rdata", expected, rdata);
  endtask

  task automatic write_phase(input int ch, input logic [PHASE_BITS-1:0] inc);
    dds_reg_word_t word;
    // the unused top byte gets noise that the register must drop
    word = lcg_next();
    word.phase.inc = inc;
    write_reg(AXI_ADDR_WIDTH'(ADDR_PHASE_BASE + 4 * ch), word, RESP_OKAY);
    model_inc[ch] = inc;
  endtask

  task automatic read_all_registers();
    dds_reg_word_t word;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      word = '0;
      word.phase.inc = model_inc[ch];
      read_reg(AXI_ADDR_WIDTH'(ADDR_PHASE_BASE + 4 * ch), word, RESP_OKAY);
    end
    word = '0;
    word.control.enable = model_mask;
    read_reg(ADDR_CONTROL, word, RESP_OKAY);
  endtask

  // arms the checker, then restarts all accumulators with a clear and the given mask
  task automatic run_stream(input logic [CHANNELS-1:0] mask, input int samples);
    dds_reg_word_t word;
    word = '0;
    word.control.enable = mask;
    word.control.clear = 1'b1;
    model_mask = mask;
    check_inc = model_inc;
    check_mask = mask;
    check_len = samples;
    check_req = 1'b1;
    write_reg(ADDR_CONTROL, word, RESP_OKAY);
    wait (!check_req);
    @(posedge ps_clk);
  endtask

  // a first write is accepted, its response is held back while a second write waits
  task automatic stalled_write(input int ch, input logic [AXI_ADDR_WIDTH-1:0] next_addr);
    logic [1:0] held;
    logic [1:0] resp;
    model_inc[ch] = PHASE_BITS'(lcg_next());
    awaddr <= AXI_ADDR_WIDTH'(ADDR_PHASE_BASE + 4 * ch);
    wdata <= AXI_DATA_WIDTH'(model_inc[ch]);
    wstrb <= '1;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    do @(posedge ps_clk); while (!awready);
    awaddr <= next_addr;
    @(posedge ps_clk);
    held = bresp;
    repeat (2 + random_below(6)) begin
      checks++;
      if (!bvalid || bresp !== held || awready) begin
        errors++;
        $display("Write response not held, or a new write was taken while bready was low");
      end
      @(posedge ps_clk);
    end
    compare_resp("bresp", RESP_OKAY, held);
    bready <= 1'b1;
    do @(posedge ps_clk); while (!awready);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    wait_write_response(resp);
    compare_resp("bresp", RESP_SLVERR, resp);
  endtask

  // the same rule on the read side, the second read hits an unmapped address
  task automatic stalled_read(input int ch, input logic [AXI_ADDR_WIDTH-1:0] next_addr);
    dds_reg_word_t held;
    dds_reg_word_t word;
    word = '0;
    word.phase.inc = model_inc[ch];
    araddr <= AXI_ADDR_WIDTH'(ADDR_PHASE_BASE + 4 * ch);
    arvalid <= 1'b1;
    do @(posedge ps_clk); while (!arready);
    araddr <= next_addr;
    @(posedge ps_clk);
    held = rdata;
    repeat (2 + random_below(6)) begin
      checks++;
      if (!rvalid || rdata !== held || arready) begin
        errors++;
        $display("Read response not held, or a new read was taken while rready was low");
      end
      @(posedge ps_clk);
    end
    compare_word("rdata", word, held);
    rready <= 1'b1;
    do @(posedge ps_clk); while (!arready);
    arvalid <= 1'b0;
    // the second read was taken on that edge, its error response follows with rready still high
    do @(posedge ps_clk); while (!rvalid);
    rready <= 1'b0;
    compare_resp("rresp", RESP_SLVERR, rresp);
    compare_word("rdata", '0, rdata);
  endtask

  // counts valid words after the clear and compares every channel with the reference
  initial begin : sample_checker
    int count;
    int low_cycles;
    logic signed [DATA_WIDTH-1:0] expected;
    forever begin
      wait (check_req);
      // sample_valid falls after the clear, the next valid word is the first of the run
      @(posedge ps_clk);
      while (sample_valid) @(posedge ps_clk);
      // the edge that ended the loop already saw the first low cycle
      low_cycles = 1;
      count = 0;
      while (count < check_len) begin
        @(posedge ps_clk);
        if (sample_valid) begin
          if (count == 0) begin
            checks++;
            if (low_cycles != VALID_GAP) begin
              errors++;
              $display("Error at %0t: sample_valid low for %0d cycles, expected %0d",
                       $time, low_cycles, VALID_GAP);
            end
          end
          for (int ch = 0; ch < CHANNELS; ch++) begin
            expected = '0;
            if (check_mask[ch]) begin
              expected = cos_ref(PHASE_BITS'(longint'(count) * check_inc[ch]));
            end
            compare_sample($sformatf("sample_data[%0d]", ch), expected,
                           sample_data[ch*DATA_WIDTH +: DATA_WIDTH]);
          end
          count++;
        end else if (count == 0) begin
          low_cycles++;
        end
      end
      check_req = 1'b0;
    end
  end

  initial begin : main
    dds_reg_word_t word;
    logic [CHANNELS-1:0] mask;
    logic [PHASE_BITS-1:0] tmp;
    int j;
    int first_error;
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    model_mask = '0;
    foreach (model_inc[ch]) model_inc[ch] = '0;
    repeat (10) @(posedge ps_clk);
    rst <= 1'b0;
    @(posedge ps_clk);

    first_error = errors;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      write_phase(ch, PHASE_BITS'(lcg_next()));
    end
    // random control word, only the mask may come back
    word = lcg_next();
    write_reg(ADDR_CONTROL, word, RESP_OKAY);
    model_mask = word.control.enable;
    read_all_registers();
    report_test("register readback", first_error);

    first_error = errors;
    foreach (bad_addrs[i]) begin
      write_reg(bad_addrs[i], lcg_next(), RESP_SLVERR);
      read_reg(bad_addrs[i], '0, RESP_SLVERR);
    end
    read_all_registers();
    report_test("address errors", first_error);

    for (int set = 0; set < 3; set++) begin
      first_error = errors;
      for (int i = CHANNELS - 1; i > 0; i--) begin
        j = random_below(i + 1);
        tmp = freq_set[i];
        freq_set[i] = freq_set[j];
        freq_set[j] = tmp;
      end
      for (int ch = 0; ch < CHANNELS; ch++) begin
        write_phase(ch, freq_set[ch]);
      end
      run_stream('1, STEADY_SAMPLES);
      report_test($sformatf("steady frequencies set %0d", set), first_error);
    end

    first_error = errors;
    mask = CHANNELS'(lcg_next() >> 20);
    run_stream(mask, MASK_SAMPLES);
    report_test("enable mask", first_error);

    // new increments while the stream runs, then a restart from phase zero
    first_error = errors;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      write_phase(ch, PHASE_BITS'(lcg_next()));
    end
    run_stream(model_mask, RESTART_SAMPLES);
    report_test("phase restart", first_error);

    first_error = errors;
    stalled_write(3, 6'h28);
    stalled_read(5, 6'h34);
    read_all_registers();
    report_test("back-pressure", first_error);

    errors += dds_bank_i.dds_bank_properties_i.failures;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* dds_bank.f */
common/dds_pkg.sv
source/dds_regs.sv
dds_channel/quarter_wave_cos.sv
dds_channel/dds_channel.sv
source/sample_packer.sv
source/dds_bank.sv
tb/dds_bank_properties.sv
tb/dds_bank_tb.sv

/* Bender.yml */
package:
  name: dds_bank

sources:
  - common/dds_pkg.sv
  - source/dds_regs.sv
  - dds_channel/quarter_wave_cos.sv
  - dds_channel/dds_channel.sv
  - source/sample_packer.sv
  - source/dds_bank.sv
  - target: test
    files:
      - tb/dds_bank_properties.sv
      - tb/dds_bank_tb.sv
